// File: trk_defs.svh
`ifndef TRK_DEFS_SVH
`define TRK_DEFS_SVH

////////////////////////////////////////////////////////////
// Word widths
////////////////////////////////////////////////////////////

`define TRK_PHASE_W     13      // Phase and frequency words
`define TRK_CORR_W      8       // Signed correlation sum

////////////////////////////////////////////////////////////
// Loop constants
////////////////////////////////////////////////////////////

// Cycles per integration window
`define TRK_DUMP_LEN    64

`define TRK_PHASE_STEP  13'h0200    // Phase correction per decision
`define TRK_QUARTER     13'h0800    // Q code leads I by this much

// Magnitude treated as a strong correlation
`define TRK_STRONG_THR  32

`endif

// File: trk_signal_pkg.sv
`include "trk_defs.svh"

package trk_signal_pkg;

    ////////////////////////////////////////////////////////////
    // Oscillator words
    ////////////////////////////////////////////////////////////

    // Used for both the frequency word and the phase word
    typedef logic [`TRK_PHASE_W-1:0] phase_word_t;

    ////////////////////////////////////////////////////////////
    // Correlator results
    ////////////////////////////////////////////////////////////

    // Agree count minus disagree count over one window
    typedef logic signed [`TRK_CORR_W-1:0] corr_t;

    // Latched I and Q sums, one pair per dump
    typedef struct packed {
        corr_t i_corr;  // In-phase arm
        corr_t q_corr;  // Quadrature arm
    } corr_pair_t;

endpackage

// File: trk_loop_pkg.sv
package trk_loop_pkg;

    ////////////////////////////////////////////////////////////
    // Decision codes
    ////////////////////////////////////////////////////////////

    // Codes 1 to 4 move the phase word, 5 and 8 leave it alone
    typedef enum logic [3:0] {
        DEC_NONE       = 4'd0,
        DEC_ADV_POS    = 4'd1,  // I negative, Q strong positive
        DEC_RET_POS    = 4'd2,  // I negative, Q strong negative
        DEC_RET_NEG    = 4'd3,  // I positive, Q strong positive
        DEC_ADV_NEG    = 4'd4,  // I positive, Q strong negative
        DEC_IN_PHASE   = 4'd5,
        DEC_ANTI_PHASE = 4'd8
    } decision_e;

    ////////////////////////////////////////////////////////////
    // Report
    ////////////////////////////////////////////////////////////

    // Published once per window
    typedef struct packed {
        logic                        locked;    // Strong positive I
        decision_e                   decision;
        trk_signal_pkg::phase_word_t phase;     // Phase word after the update
        trk_signal_pkg::corr_pair_t  corr;      // Sums the decision was made on
    } trk_report_t;

endpackage

// File: code_nco.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module code_nco (
    input  logic                        clk,
    input  logic                        rst_in,
    input  trk_signal_pkg::phase_word_t i_fcw,
    input  trk_signal_pkg::phase_word_t i_phase_ofs,
    output logic                        o_code
);

    import trk_signal_pkg::*;

    phase_word_t acc;
    phase_word_t phase;

    ////////////////////////////////////////////////////////////
    // Phase accumulator
    ////////////////////////////////////////////////////////////

    // Wraps modulo 2^TRK_PHASE_W
    always_ff @(posedge clk) begin
        if (rst_in) begin
            acc <= '0;
        end else begin
            acc <= acc + i_fcw;
        end
    end

    ////////////////////////////////////////////////////////////
    // Code output
    ////////////////////////////////////////////////////////////

    // Offset applied after the register so a new phase word
    // shows up on the very next cycle
    assign phase = acc + i_phase_ofs;

    // Top bit of the phase gives a square wave
    assign o_code = phase[`TRK_PHASE_W-1];

endmodule

// File: code_correlator.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module code_correlator (
    input  logic                  clk,
    input  logic                  rst_in,
    input  logic                  i_sig,
    input  logic                  i_code,
    input  logic                  i_dump,
    output trk_signal_pkg::corr_t o_corr
);

    import trk_signal_pkg::*;

    corr_t run;     // Running sum for the open window
    corr_t term;
    corr_t sum;

    ////////////////////////////////////////////////////////////
    // Integrate and dump
    ////////////////////////////////////////////////////////////

    assign term = (i_sig == i_code) ? corr_t'(1) : corr_t'(-1);
    assign sum  = run + term;  // Includes this cycle's sample

    always_ff @(posedge clk) begin
        if (rst_in) begin
            run    <= '0;
            o_corr <= '0;
        end else if (i_dump) begin
            o_corr <= sum;     // Held until the next dump
            run    <= '0;
        end else begin
            run    <= sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // A window never holds more samples than the timer allows,
    // so the sum cannot walk past the window length
    a_run_bounded: assert property (
        @(posedge clk) disable iff (rst_in)
        (run <= `TRK_DUMP_LEN) && (run >= -(`TRK_DUMP_LEN))
    ) else $error("correlator sum %0d beyond window length", run);

endmodule

// File: dump_timer.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module dump_timer (
    input  logic clk,
    input  logic rst_in,
    output logic o_dump
);

    localparam int CNT_W = $clog2(`TRK_DUMP_LEN);

    logic [CNT_W-1:0] cnt;
    logic             last;

    assign last = (cnt == CNT_W'(`TRK_DUMP_LEN - 1));

    ////////////////////////////////////////////////////////////
    // Window counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_in) begin
            cnt <= '0;
        end else if (last) begin
            cnt <= '0;  // Window closes
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_dump = last;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Back to back dumps would give a one-sample window
    a_dump_single: assert property (
        @(posedge clk) disable iff (rst_in) o_dump |=> !o_dump
    ) else $error("dump pulse on consecutive cycles");

endmodule

// File: phase_discriminator.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module phase_discriminator (
    input  logic                        clk,
    input  logic                        rst_in,
    input  logic                        i_dump,
    input  trk_signal_pkg::corr_pair_t  i_corr,
    output trk_signal_pkg::phase_word_t o_pcw,
    output trk_loop_pkg::trk_report_t   o_report,
    output logic                        o_valid
);

    import trk_signal_pkg::*;
    import trk_loop_pkg::*;

    logic        eval;          // Cycle after dump, sums are fresh
    logic        i_neg;
    logic        q_pos;
    logic        q_neg;
    decision_e   decision;
    phase_word_t pcw;
    phase_word_t pcw_next;
    trk_report_t report_q;
    trk_report_t report_next;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            eval <= 1'b0;
        end else begin
            eval <= i_dump;
        end
    end

    ////////////////////////////////////////////////////////////
    // Quadrant decision
    ////////////////////////////////////////////////////////////

    assign i_neg = i_corr.i_corr < 0;
    assign q_pos = i_corr.q_corr >= `TRK_STRONG_THR;
    assign q_neg = i_corr.q_corr <= -(`TRK_STRONG_THR);

    // First matching row wins
    always_comb begin
        pcw_next = pcw;
        if (i_neg && q_pos) begin
            decision = DEC_ADV_POS;
            pcw_next = pcw + `TRK_PHASE_STEP;
        end else if (i_neg && q_neg) begin
            decision = DEC_RET_POS;
            pcw_next = pcw - `TRK_PHASE_STEP;
        end else if (!i_neg && q_pos) begin
            decision = DEC_RET_NEG;
            pcw_next = pcw - `TRK_PHASE_STEP;
        end else if (!i_neg && q_neg) begin
            decision = DEC_ADV_NEG;
            pcw_next = pcw + `TRK_PHASE_STEP;
        end else if (i_corr.i_corr >= `TRK_STRONG_THR) begin
            decision = DEC_IN_PHASE;
        end else if (i_corr.i_corr <= -(`TRK_STRONG_THR)) begin
            decision = DEC_ANTI_PHASE;
        end else begin
            decision = DEC_NONE;
        end
    end

    assign report_next = '{
        locked:   (i_corr.i_corr >= `TRK_STRONG_THR),
        decision: decision,
        phase:    pcw_next,
        corr:     i_corr
    };

    ////////////////////////////////////////////////////////////
    // Phase word and report
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_in) begin
            pcw      <= '0;
            report_q <= '0;
        end else if (eval) begin
            pcw      <= pcw_next;
            report_q <= report_next;
        end
    end

    assign o_pcw   = pcw;
    assign o_valid = eval;

    // Fresh report on the valid cycle, then held until the next window
    assign o_report = eval ? report_next : report_q;

endmodule

// File: phase_tracker.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module phase_tracker (
    input  logic                        clk,
    input  logic                        rst_in,
    input  logic                        i_sig,
    input  trk_signal_pkg::phase_word_t i_fcw,
    output trk_loop_pkg::trk_report_t   o_report,
    output logic                        o_valid
);

    import trk_signal_pkg::*;

    phase_word_t pcw;
    phase_word_t pcw_q;     // Quarter turn ahead of pcw
    logic        code_i;
    logic        code_q;
    logic        dump;
    corr_t       corr_i;
    corr_t       corr_q;
    corr_pair_t  corr_pair;

    assign pcw_q = pcw + `TRK_QUARTER;

    ////////////////////////////////////////////////////////////
    // Code oscillators
    ////////////////////////////////////////////////////////////

    code_nco u_nco_i (
        .clk         (clk),
        .rst_in      (rst_in),
        .i_fcw       (i_fcw),
        .i_phase_ofs (pcw),
        .o_code      (code_i)
    );

    code_nco u_nco_q (
        .clk         (clk),
        .rst_in      (rst_in),
        .i_fcw       (i_fcw),
        .i_phase_ofs (pcw_q),
        .o_code      (code_q)
    );

    ////////////////////////////////////////////////////////////
    // Correlators and window timing
    ////////////////////////////////////////////////////////////

    code_correlator u_corr_i (
        .clk    (clk),
        .rst_in (rst_in),
        .i_sig  (i_sig),
        .i_code (code_i),
        .i_dump (dump),
        .o_corr (corr_i)
    );

    code_correlator u_corr_q (
        .clk    (clk),
        .rst_in (rst_in),
        .i_sig  (i_sig),
        .i_code (code_q),
        .i_dump (dump),
        .o_corr (corr_q)
    );

    dump_timer u_dump (
        .clk    (clk),
        .rst_in (rst_in),
        .o_dump (dump)
    );

    assign corr_pair = '{i_corr: corr_i, q_corr: corr_q};

    // Closes the loop back to the oscillators
    phase_discriminator u_disc (
        .clk      (clk),
        .rst_in   (rst_in),
        .i_dump   (dump),
        .i_corr   (corr_pair),
        .o_pcw    (pcw),
        .o_report (o_report),
        .o_valid  (o_valid)
    );

endmodule

// File: tb_phase_tracker.sv
`timescale 1ns/100ps

`include "trk_defs.svh"

module tb_phase_tracker;

    import trk_signal_pkg::*;
    import trk_loop_pkg::*;

    localparam int PHASE_MOD = 1 << `TRK_PHASE_W;
    localparam int WAIT_MAX  = 2 * `TRK_DUMP_LEN;   // Longest allowed gap between reports
    localparam int SRC_WAVE  = 0;
    localparam int SRC_INV   = 1;
    localparam int SRC_RAND  = 2;
    localparam int SRC_NOISY = 3;

    logic        clk;
    logic        rst_in;
    logic        i_sig;
    phase_word_t i_fcw;
    trk_report_t o_report;
    logic        o_valid;

    // Reference model state, one step per clock
    int          m_acc;
    int          m_pcw;
    int          m_run_i;
    int          m_run_q;
    int          m_corr_i;
    int          m_corr_q;
    int          m_cnt;
    logic        m_eval;

    logic        exp_live;      // Model is in step with the DUT
    logic        exp_valid;
    trk_report_t exp_report;
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          n_reports;

    phase_tracker i_phase_tracker (
        .clk      (clk),
        .rst_in   (rst_in),
        .i_sig    (i_sig),
        .i_fcw    (i_fcw),
        .o_report (o_report),
        .o_valid  (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    // Square wave level for a phase taken modulo the word size
    function automatic logic phase_msb(input int p);
        return ((p & (PHASE_MOD - 1)) >= (PHASE_MOD / 2));
    endfunction

    function automatic trk_report_t decide(input int ci, input int cq, input int pcw);
        trk_report_t r;
        int          step;
        step       = 0;
        r.decision = DEC_NONE;
        if (ci < 0 && cq >= `TRK_STRONG_THR) begin
            r.decision = DEC_ADV_POS;
            step       = `TRK_PHASE_STEP;
        end else if (ci < 0 && cq <= -`TRK_STRONG_THR) begin
            r.decision = DEC_RET_POS;
            step       = -`TRK_PHASE_STEP;
        end else if (ci >= 0 && cq >= `TRK_STRONG_THR) begin
            r.decision = DEC_RET_NEG;
            step       = -`TRK_PHASE_STEP;
        end else if (ci >= 0 && cq <= -`TRK_STRONG_THR) begin
            r.decision = DEC_ADV_NEG;
            step       = `TRK_PHASE_STEP;
        end else if (ci >= `TRK_STRONG_THR) begin
            r.decision = DEC_IN_PHASE;
        end else if (ci <= -`TRK_STRONG_THR) begin
            r.decision = DEC_ANTI_PHASE;
        end
        r.locked      = (ci >= `TRK_STRONG_THR);
        r.phase       = phase_word_t'((pcw + step) & (PHASE_MOD - 1));
        r.corr.i_corr = corr_t'(ci);
        r.corr.q_corr = corr_t'(cq);
        return r;
    endfunction

    task automatic model_reset();
        m_acc    = 0;
        m_pcw    = 0;
        m_run_i  = 0;
        m_run_q  = 0;
        m_corr_i = 0;
        m_corr_q = 0;
        m_cnt    = 0;
        m_eval   = 1'b0;
    endtask

    // One rising edge of the whole loop, all terms from the old state
    task automatic model_step(input logic sig, input int fcw);
        logic        code_i;
        logic        code_q;
        logic        dump;
        int          t_i;
        int          t_q;
        trk_report_t nxt;
        code_i = phase_msb(m_acc + m_pcw);
        code_q = phase_msb(m_acc + m_pcw + `TRK_QUARTER);
        dump   = (m_cnt == `TRK_DUMP_LEN - 1);
        nxt    = decide(m_corr_i, m_corr_q, m_pcw);
        t_i    = (sig == code_i) ? 1 : -1;
        t_q    = (sig == code_q) ? 1 : -1;
        if (m_eval) begin
            m_pcw = nxt.phase;
        end
        if (dump) begin
            m_corr_i = m_run_i + t_i;
            m_corr_q = m_run_q + t_q;
            m_run_i  = 0;
            m_run_q  = 0;
        end else begin
            m_run_i = m_run_i + t_i;
            m_run_q = m_run_q + t_q;
        end
        m_eval = dump;
        m_cnt  = dump ? 0 : m_cnt + 1;
        m_acc  = (m_acc + fcw) % PHASE_MOD;
    endtask

    task automatic publish_expected();
        exp_valid  = m_eval;
        exp_report = decide(m_corr_i, m_corr_q, m_pcw);
        exp_live   = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs only move on the rising edge, so they are settled here
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (exp_live) begin
                check_value("o_valid", o_valid, exp_valid);
                if (exp_valid) begin
                    n_reports = n_reports + 1;
                    check_value("o_report.locked", o_report.locked, exp_report.locked);
                    check_value("o_report.decision", o_report.decision, exp_report.decision);
                    check_value("o_report.phase", o_report.phase, exp_report.phase);
                    check_value("o_report.corr.i_corr", o_report.corr.i_corr,
                                exp_report.corr.i_corr);
                    check_value("o_report.corr.q_corr", o_report.corr.q_corr,
                                exp_report.corr.q_corr);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(negedge clk);
        exp_live = 1'b0;
        rst_in   = 1'b1;
        repeat (2) @(negedge clk);
        rst_in = 1'b0;
        model_reset();
        publish_expected();
    endtask

    // Called just after a falling edge, returns just after the next one
    task automatic run_cycle(input logic sig, input phase_word_t fcw, output logic valid);
        i_sig = sig;
        i_fcw = fcw;
        model_step(sig, fcw);
        @(negedge clk);
        publish_expected();
        valid = o_valid;
    endtask

    task automatic pick_sig(input int mode, input int ofs, output logic sig);
        logic noise;
        case (mode)
            SRC_WAVE: sig = phase_msb(m_acc + ofs);
            SRC_INV:  sig = !phase_msb(m_acc + ofs);
            SRC_RAND: begin
                lfsr = lfsr_next(lfsr);
                sig  = lfsr[0];
            end
            default: begin  // Wave with about a quarter of the samples flipped
                lfsr  = lfsr_next(lfsr);
                noise = lfsr[0];
                lfsr  = lfsr_next(lfsr);
                noise = noise & lfsr[0];
                sig   = phase_msb(m_acc + ofs) ^ noise;
            end
        endcase
    endtask

    task automatic wait_report(output int cycles);
        logic valid;
        valid  = 1'b0;
        cycles = 0;
        while (!valid && cycles < WAIT_MAX) begin
            run_cycle(1'b0, 13'h0200, valid);
            cycles = cycles + 1;
        end
        if (!valid) begin
            $display("Timeout: no o_valid pulse within %0d cycles", WAIT_MAX);
            n_errors = n_errors + 1;
        end
    endtask

    // want_dec below zero leaves every field to the compare process
    task automatic run_windows(
        input int          mode,
        input int          ofs,
        input phase_word_t fcw,
        input int          n_win,
        input int          want_dec
    );
        logic sig;
        logic valid;
        int   seen;
        int   idle;
        seen = 0;
        idle = 0;
        while (seen < n_win && idle < WAIT_MAX) begin
            pick_sig(mode, ofs, sig);
            run_cycle(sig, fcw, valid);
            idle = idle + 1;
            if (valid) begin
                seen = seen + 1;
                idle = 0;
                if (want_dec >= 0) begin
                    check_value("o_report.decision", o_report.decision, want_dec);
                    check_value("o_report.locked", o_report.locked, want_dec == DEC_IN_PHASE);
                    check_value("o_report.phase", o_report.phase, 0);
                end
            end
        end
        if (seen < n_win) begin
            $display("Timeout: only %0d of %0d reports arrived", seen, n_win);
            n_errors = n_errors + 1;
        end
    endtask

    task automatic test_done(input string name, input int err_before);
        $display("test %-16s %s (%0d errors)", name,
                 (n_errors == err_before) ? "ok" : "mismatch", n_errors - err_before);
    endtask

    initial begin
        int err0;
        int cyc;
        rst_in     = 1'b1;
        i_sig      = 1'b0;
        i_fcw      = '0;
        exp_live   = 1'b0;
        exp_valid  = 1'b0;
        exp_report = '0;
        lfsr       = 32'h32fc;
        n_checks   = 0;
        n_errors   = 0;
        n_reports  = 0;
        model_reset();

        err0 = n_errors;
        apply_reset();
        wait_report(cyc);
        check_value("first o_valid cycle", cyc + 1, `TRK_DUMP_LEN + 1);
        test_done("reset quiet", err0);

        err0 = n_errors;
        for (int w = 0; w < 10; w++) begin
            wait_report(cyc);
            check_value("o_valid interval", cyc, `TRK_DUMP_LEN);
        end
        test_done("report cadence", err0);

        err0 = n_errors;
        apply_reset();
        run_windows(SRC_WAVE, 0, 13'h0200, 6, DEC_IN_PHASE);
        test_done("aligned", err0);

        err0 = n_errors;
        apply_reset();
        run_windows(SRC_INV, 0, 13'h0200, 6, DEC_ANTI_PHASE);
        test_done("inverted", err0);

        err0 = n_errors;
        apply_reset();
        run_windows(SRC_WAVE, `TRK_QUARTER, 13'h0200, 8, -1);
        run_windows(SRC_WAVE, PHASE_MOD - `TRK_QUARTER, 13'h0200, 8, -1);
        test_done("shifted", err0);

        err0 = n_errors;
        apply_reset();
        run_windows(SRC_RAND, 0, 13'h0200, 5, -1);
        run_windows(SRC_NOISY, 0, 13'h0155, 5, -1);
        run_windows(SRC_RAND, 0, 13'h00c8, 5, -1);
        run_windows(SRC_NOISY, 0, 13'h0333, 5, -1);
        test_done("random", err0);

        #2;
        $display("%0d checks, %0d reports, %0d errors", n_checks, n_reports, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: phase_tracker.f
+incdir+.
trk_signal_pkg.sv
trk_loop_pkg.sv
code_nco.sv
code_correlator.sv
dump_timer.sv
phase_discriminator.sv
phase_tracker.sv
tb_phase_tracker.sv

// File: run_sim.sh
#!/bin/sh
# Build the phase tracker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_phase_tracker -Mdir "$OBJ" \
    -f phase_tracker.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_phase_tracker" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
